// ==== dcache_fill.f ====
+incdir+bench
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/cache_data_array.sv
hw/cache_tag_array.sv
hw/cache_fill_fsm.sv
hw/main_mem.sv
hw/mem_system.sv
bench/mem_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the data cache testbench with Verilator
# exit status is 0 only when the run reports a pass

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --assert -j 0 \
  --top-module mem_system_tb \
  -Mdir obj_dir \
  -f dcache_fill.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmem_system_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== bench/mem_system_ref.svh ====
`ifndef MEM_SYSTEM_REF_SVH
`define MEM_SYSTEM_REF_SVH

//////////////////////////////////////////////////////////////////////
// shadow of main memory and of the cache tags
//////////////////////////////////////////////////////////////////////
cache_pkg::word_t                ref_mem [mem_pkg::MEM_WORDS];   // always current, write-through
cache_pkg::tag_t                 ref_tag [cache_pkg::NUM_LINES];
logic [cache_pkg::NUM_LINES-1:0] ref_valid;                      // one bit per line

// power-up word, byte address xor key
function automatic cache_pkg::word_t pattern_word(cache_pkg::addr_t a);
  return a ^ 16'h5a3c;
endfunction

// memory image as at time zero, cold cache
task automatic ref_reset();
  for (int i = 0; i < mem_pkg::MEM_WORDS; i++)
    ref_mem[i] = pattern_word(cache_pkg::addr_t'(2 * i));
  ref_valid = '0;
endtask

// direct mapped: tag addr[15:8] stored at line addr[7:4]
function automatic logic ref_hit(cache_pkg::addr_t a);
  return ref_valid[a[7:4]] && (ref_tag[a[7:4]] == a[15:8]);
endfunction

// every access allocates its line, a write lands in memory as well
task automatic ref_access(input logic wr, input cache_pkg::addr_t a,
                          input cache_pkg::word_t d);
  ref_valid[a[7:4]] = 1'b1;
  ref_tag[a[7:4]]   = a[15:8];
  if (wr)
    ref_mem[a[15:1]] = d;       // word index, byte bit dropped
endtask

// stall length of one miss
// eight issue slots, latency of the last read, plus issue slots lost to pause
function automatic int expected_stall(int paused);
  return cache_pkg::BLOCK_WORDS + mem_pkg::MEM_LATENCY + paused;
endfunction

`endif

// ==== bench/mem_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;

  localparam int WAIT_LIMIT = 200;   // cycles allowed per stall wait

  // one finished access as seen on the core port
  typedef struct packed {
    logic             wr;
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
    cache_pkg::word_t rdata;
    int               stall_cycles;
    int               paused;        // issue slots lost to pause
  } obs_t;

  logic                 clk;
  logic                 arst_n;
  logic                 pause;
  logic                 stall;
  cache_pkg::core_req_t core_req;
  cache_pkg::word_t     rdata;

  obs_t obs_q [$];    // accesses waiting for the compare process
  event obs_ev;
  int   err_cnt;
  int   check_cnt;
  int   test_cnt;
  int   test_fail;

  `include "mem_system_ref.svh"

  mem_system dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .core_req (core_req),
    .pause    (pause),
    .rdata    (rdata),
    .stall    (stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks and run control
  //////////////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic end_run();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  endtask

  task automatic end_test(input string name, input int err_before);
    @(posedge clk);   // compare process has drained by now
    #1;
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  // pause either in a fixed window of cycles or on about one cycle in four
  function automatic logic pick_pause(int cyc, int start, int len, bit rnd);
    if (rnd)
      return ($urandom % 4) == 0;
    return (cyc >= start) && (cyc < start + len);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // one core access held until stall drops
  //////////////////////////////////////////////////////////////////////
  task automatic run_access(input logic wr, input cache_pkg::addr_t addr,
                            input cache_pkg::word_t wdata, input int p_start,
                            input int p_len, input bit p_rand,
                            output cache_pkg::word_t rd, output int paused);
    obs_t o;
    int   cyc;
    int   issued;
    int   stall_cycles;
    @(posedge clk);
    #1;
    core_req.valid = 1'b1;
    core_req.wr    = wr;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    cyc          = 0;
    issued       = 0;
    paused       = 0;
    stall_cycles = 0;
    pause        = pick_pause(0, p_start, p_len, p_rand);
    #1;
    while (stall && cyc < WAIT_LIMIT) begin
      stall_cycles++;
      if (issued < cache_pkg::BLOCK_WORDS) begin
        if (pause)
          paused++;      // no read leaves in this slot
        else
          issued++;
      end
      cyc++;
      @(posedge clk);
      #1;
      pause = pick_pause(cyc, p_start, p_len, p_rand);
      #1;                // sample mid cycle
    end
    if (stall) begin
      err_cnt++;
      $display("timeout: stall still high after %0d cycles at address %h", WAIT_LIMIT, addr);
      end_run();
    end else begin
      rd             = rdata;
      o.wr           = wr;
      o.addr         = addr;
      o.wdata        = wdata;
      o.rdata        = rdata;
      o.stall_cycles = stall_cycles;
      o.paused       = paused;
      obs_q.push_back(o);
      -> obs_ev;
      @(posedge clk);    // accepted at this edge
      #1;
      core_req.valid = 1'b0;
      pause          = 1'b0;
    end
  endtask

  // compares every access against the shadow model in order
  initial begin : compare_proc
    obs_t o;
    logic exp_hit;
    forever begin
      @(obs_ev);
      while (obs_q.size() != 0) begin
        o       = obs_q.pop_front();
        exp_hit = ref_hit(o.addr);
        check_count($sformatf("stall cycles at %h", o.addr), o.stall_cycles,
                    exp_hit ? 0 : expected_stall(o.paused));
        ref_access(o.wr, o.addr, o.wdata);
        if (!o.wr)
          check_word($sformatf("rdata at %h", o.addr), o.rdata, ref_mem[o.addr[15:1]]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    int               e;
    int               pz;
    cache_pkg::word_t rd;
    cache_pkg::addr_t a;
    void'($urandom(32'hd1c6));
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    test_fail = 0;
    arst_n    = 1'b0;
    pause     = 1'b0;
    core_req  = '0;
    ref_reset();
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;

    // every first read of a cold cache misses, one read per line
    e = err_cnt;
    @(posedge clk);
    #2;
    check_count("stall after reset", int'(stall), 0);
    for (int i = 0; i < cache_pkg::NUM_LINES; i++)
      run_access(1'b0, {8'h10, 4'(i), 3'd0, 1'b0}, '0, 0, 0, 1'b0, rd, pz);
    end_test("cold misses", e);

    // read miss then hits on the whole line
    e = err_cnt;
    run_access(1'b0, 16'h1234, '0, 0, 0, 1'b0, rd, pz);
    for (int w = 0; w < 8; w++)
      run_access(1'b0, 16'h1230 + 16'(w * 2), '0, 0, 0, 1'b0, rd, pz);
    end_test("read miss fill", e);

    // write hit followed by an evict and a reread from memory
    e = err_cnt;
    run_access(1'b1, 16'h1236, 16'hbeef, 0, 0, 1'b0, rd, pz);
    run_access(1'b0, 16'h1236, '0, 0, 0, 1'b0, rd, pz);
    run_access(1'b0, 16'h5536, '0, 0, 0, 1'b0, rd, pz);   // same index 3
    run_access(1'b0, 16'h1236, '0, 0, 0, 1'b0, rd, pz);
    end_test("write hit and evict", e);

    // write miss allocates and neighbors keep the pattern
    e = err_cnt;
    run_access(1'b1, 16'h3456, 16'hc0de, 0, 0, 1'b0, rd, pz);
    for (int w = 0; w < 8; w++)
      run_access(1'b0, 16'h3450 + 16'(w * 2), '0, 0, 0, 1'b0, rd, pz);
    end_test("write miss", e);

    // pause windows inside the issue phase
    e = err_cnt;
    run_access(1'b0, 16'h7a74, '0, 2, 3, 1'b0, rd, pz);
    check_count("paused issue cycles", pz, 3);
    run_access(1'b0, 16'h7b86, '0, 0, 5, 1'b0, rd, pz);   // paused from the miss cycle
    check_count("paused issue cycles", pz, 5);
    for (int w = 0; w < 8; w++)
      run_access(1'b0, 16'h7a70 + 16'(w * 2), '0, 0, 0, 1'b0, rd, pz);
    end_test("pause during fill", e);

    // random mix over four indices and three tags
    e = err_cnt;
    for (int n = 0; n < 300; n++) begin
      a = {8'h20 + 8'($urandom % 3), 4'($urandom % 4), 3'($urandom % 8), 1'b0};
      run_access(($urandom % 3) == 0, a, 16'($urandom), 0, 0, 1'b1, rd, pz);
    end
    end_test("random traffic", e);

    end_run();
  end

endmodule

`default_nettype wire

// ==== hw/mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire cache_pkg::core_req_t core_req,
  input  wire                       pause,
  output cache_pkg::word_t          rdata,
  output logic                      stall
);

  // cache side
  logic              hit;
  logic              tag_we;
  logic              data_we;
  cache_pkg::addr_t  data_waddr;
  cache_pkg::word_t  data_wdata;

  // memory side
  mem_pkg::mem_req_t mem_req;
  cache_pkg::word_t  mem_rdata;
  logic              mem_rvalid;

  cache_fill_fsm fsm0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .core_req   (core_req),
    .hit        (hit),
    .pause      (pause),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .stall      (stall),
    .mem_req    (mem_req),
    .tag_we     (tag_we),
    .data_we    (data_we),
    .data_waddr (data_waddr),
    .data_wdata (data_wdata)
  );

  //////////////////////////////////////////////////////////////////////
  // arrays
  //////////////////////////////////////////////////////////////////////
  cache_tag_array tags0 (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (core_req.addr),   // held request names the line being filled
    .we     (tag_we),
    .hit    (hit)
  );

  cache_data_array data0 (
    .clk   (clk),
    .raddr (core_req.addr),    // read port always follows the core
    .waddr (data_waddr),
    .we    (data_we),
    .wdata (data_wdata),
    .rdata (rdata)
  );

  main_mem mem0 (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (mem_req),
    .rdata  (mem_rdata),
    .rvalid (mem_rvalid)
  );

endmodule

`default_nettype wire

// ==== hw/main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_mem (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire mem_pkg::mem_req_t req,
  output cache_pkg::word_t       rdata,
  output logic                   rvalid
);

  localparam int LAT = mem_pkg::MEM_LATENCY;

  cache_pkg::word_t  mem       [mem_pkg::MEM_WORDS];
  cache_pkg::word_t  data_pipe [LAT];     // read data in flight
  logic [LAT-1:0]    vld_pipe;            // matching valid bits
  mem_pkg::mem_idx_t idx;

  assign idx = req.addr[cache_pkg::ADDR_W-1:1];   // word index, byte bit dropped

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////
  initial begin
    for (int i = 0; i < mem_pkg::MEM_WORDS; i++)
      mem[i] = mem_pkg::init_word(mem_pkg::mem_idx_t'(i));   // known pattern at time zero
  end

  always_ff @(posedge clk) begin
    if (req.wr)
      mem[idx] <= req.wdata;      // visible to any read after this edge
  end

  //////////////////////////////////////////////////////////////////////
  // read pipeline, one new read per cycle
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      vld_pipe <= '0;
    else
      vld_pipe <= {vld_pipe[LAT-2:0], req.rd};
  end

  always_ff @(posedge clk) begin
    data_pipe[0] <= mem[idx];     // sampled every cycle, only tagged ones count
    for (int s = 1; s < LAT; s++)
      data_pipe[s] <= data_pipe[s-1];
  end

  assign rvalid = vld_pipe[LAT-1];   // LAT cycles after rd
  assign rdata  = data_pipe[LAT-1];

endmodule

`default_nettype wire

// ==== hw/cache_fill_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm (
  input  wire                  clk,
  input  wire                  arst_n,
  input  wire cache_pkg::core_req_t core_req,
  input  wire                  hit,          // tag match for core_req.addr
  input  wire                  pause,        // another agent owns the memory port
  input  wire                  mem_rvalid,
  input  wire cache_pkg::word_t mem_rdata,
  output logic                 stall,
  output mem_pkg::mem_req_t    mem_req,
  output logic                 tag_we,
  output logic                 data_we,
  output cache_pkg::addr_t     data_waddr,
  output cache_pkg::word_t     data_wdata
);

  typedef enum logic {
    IDLE,
    FILL
  } fill_state_e;

  fill_state_e         state;
  fill_state_e         state_nxt;
  cache_pkg::count_t   issue_cnt;    // reads sent so far
  cache_pkg::offset_t  ret_cnt;      // next offset to be written from memory
  cache_pkg::tag_t     req_tag;
  cache_pkg::index_t   req_index;
  logic                miss;
  logic                wr_hit;
  logic                issue;
  logic                filling;
  logic                last_ret;

  // the core holds its request during a miss, so it doubles as the fill address
  assign req_tag   = cache_pkg::addr_tag(core_req.addr);
  assign req_index = cache_pkg::addr_index(core_req.addr);

  //////////////////////////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////////////////////////
  assign filling  = (state == FILL);
  assign miss     = (state == IDLE) && core_req.valid && !hit;
  assign wr_hit   = (state == IDLE) && core_req.valid && core_req.wr && hit;

  // first read leaves in the miss cycle itself, the rest from FILL
  assign issue    = !pause &&
                    (miss || (filling &&
                              issue_cnt != cache_pkg::count_t'(cache_pkg::BLOCK_WORDS)));

  assign last_ret = filling && mem_rvalid &&
                    (ret_cnt == cache_pkg::offset_t'(cache_pkg::BLOCK_WORDS - 1));

  //////////////////////////////////////////////////////////////////////
  // state and counters
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: if (miss) state_nxt = FILL;
      FILL: if (last_ret) state_nxt = IDLE;   // held request hits next cycle
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      issue_cnt <= '0;
      ret_cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (last_ret)
        issue_cnt <= '0;                      // ready for the next miss
      else if (issue)
        issue_cnt <= issue_cnt + 1'b1;        // pause holds it here
      if (filling && mem_rvalid)
        ret_cnt <= ret_cnt + 1'b1;            // wraps to 0 on the last word
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory port
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    mem_req.rd    = issue;                    // one read per unpaused issue slot
    mem_req.wr    = wr_hit;                   // write-through lands at the array's edge
    mem_req.addr  = core_req.addr;
    mem_req.wdata = core_req.wdata;
    if (issue)
      mem_req.addr = cache_pkg::block_addr(req_tag, req_index,
                                           issue_cnt[cache_pkg::OFFSET_W-1:0]);
  end

  // array side
  assign stall      = filling || miss;        // combinational on the miss cycle
  assign tag_we     = last_ret;               // tag and valid with the eighth word
  assign data_we    = (filling && mem_rvalid) || wr_hit;
  assign data_waddr = filling ? cache_pkg::block_addr(req_tag, req_index, ret_cnt)
                              : core_req.addr;
  assign data_wdata = filling ? mem_rdata : core_req.wdata;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(mem_req.rd && mem_req.wr))
    else $error("cache_fill_fsm: rd and wr together");

  // every return belongs to a fill that is still open
  a_rvalid_fill: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rvalid |-> filling)
    else $error("cache_fill_fsm: mem_rvalid outside FILL");

  a_ret_le_issue: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rvalid |-> ({1'b0, ret_cnt} < issue_cnt))
    else $error("cache_fill_fsm: return without matching read");

endmodule

`default_nettype wire

// ==== hw/cache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire cache_pkg::addr_t addr,   // core address, fill address on tag_we
  input  wire                   we,
  output logic                  hit
);

  cache_pkg::tag_t                tags [cache_pkg::NUM_LINES];
  logic [cache_pkg::NUM_LINES-1:0] valid;     // one bit per line
  cache_pkg::tag_t                addr_tag;
  cache_pkg::index_t              addr_index;

  assign addr_tag   = cache_pkg::addr_tag(addr);
  assign addr_index = cache_pkg::addr_index(addr);

  // valid bits come up clear, a cold cache misses everywhere
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      valid <= '0;
    else if (we)
      valid[addr_index] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (we)
      tags[addr_index] <= addr_tag;           // recorded with the last fill word
  end

  // direct mapped, one compare
  assign hit = valid[addr_index] && (tags[addr_index] == addr_tag);

  //////////////////////////////////////////////////////////////////////
  // the FSM must present a settled fill address when it writes
  //////////////////////////////////////////////////////////////////////
  a_we_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
    we |-> !$isunknown(addr))
    else $error("cache_tag_array: tag write with unknown address");

endmodule

`default_nettype wire

// ==== hw/cache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
  input  wire                   clk,
  input  wire cache_pkg::addr_t raddr,   // core address
  input  wire cache_pkg::addr_t waddr,   // fill slot or write-hit address
  input  wire                   we,
  input  wire cache_pkg::word_t wdata,
  output cache_pkg::word_t      rdata
);

  // 16 lines x 8 words, flat
  cache_pkg::word_t words [cache_pkg::ARRAY_WORDS];
  cache_pkg::slot_t rslot;
  cache_pkg::slot_t wslot;

  assign rslot = cache_pkg::addr_slot(raddr);
  assign wslot = cache_pkg::addr_slot(waddr);

  // registered write, one port
  always_ff @(posedge clk) begin
    if (we)
      words[wslot] <= wdata;
  end

  // asynchronous read so a hit returns data in its own cycle
  assign rdata = words[rslot];

endmodule

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int MEM_LATENCY = 4;        // rd to rvalid, in cycles
  localparam int MEM_WORDS   = 32768;    // full 16 bit byte space as words
  localparam int MEM_AW      = $clog2(MEM_WORDS);

  localparam cache_pkg::word_t INIT_XOR = 16'h5a3c;   // power-up pattern key

  typedef logic [MEM_AW-1:0] mem_idx_t;   // word index, addr[15:1]

  // memory port request driven by the fill FSM
  typedef struct packed {
    logic             rd;     // starts one pipelined read
    logic             wr;     // write-through, one cycle
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
  } mem_req_t;

  // initial contents of a word, byte address xor key
  function automatic cache_pkg::word_t init_word(mem_idx_t i);
    return {i, 1'b0} ^ INIT_XOR;
  endfunction

endpackage

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry of the direct-mapped data cache
  //////////////////////////////////////////////////////////////////////
  localparam int ADDR_W      = 16;   // byte address
  localparam int WORD_W      = 16;
  localparam int TAG_W       = 8;    // addr[15:8]
  localparam int INDEX_W     = 4;    // addr[7:4]
  localparam int OFFSET_W    = 3;    // addr[3:1], word inside the line
  localparam int BLOCK_WORDS = 8;
  localparam int NUM_LINES   = 16;
  localparam int ARRAY_WORDS = BLOCK_WORDS * NUM_LINES;
  localparam int COUNT_W     = OFFSET_W + 1;   // counts 0 .. BLOCK_WORDS

  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [WORD_W-1:0]           word_t;
  typedef logic [TAG_W-1:0]            tag_t;
  typedef logic [INDEX_W-1:0]          index_t;
  typedef logic [OFFSET_W-1:0]         offset_t;
  typedef logic [INDEX_W+OFFSET_W-1:0] slot_t;    // word slot in the data array
  typedef logic [COUNT_W-1:0]          count_t;   // issued reads in a fill

  // core-side request, held by the core while stall is high
  typedef struct packed {
    logic  valid;
    logic  wr;      // 1 = write, 0 = read
    addr_t addr;
    word_t wdata;
  } core_req_t;

  // address field helpers
  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[OFFSET_W+1 +: INDEX_W];
  endfunction

  function automatic slot_t addr_slot(addr_t a);
    return a[1 +: INDEX_W+OFFSET_W];   // index and offset together
  endfunction

  // byte address of one word of a line, bit 0 always clear
  function automatic addr_t block_addr(tag_t t, index_t i, offset_t o);
    return {t, i, o, 1'b0};
  endfunction

endpackage

`default_nettype wire
